//--- common/botPermuter_settings.svh
`ifndef BOTPERMUTER_SETTINGS_SVH
`define BOTPERMUTER_SETTINGS_SVH

// Producer lanes
`define NUM_LANES 4

// Lane buffers, 128 entries each
`define LANE_DEPTH_LOG2 7
`define LANE_SLOWDOWN_FREE 24
`define LANE_READ_LATENCY 2

// Batch-order queue
`define BATCHQ_DEPTH_LOG2 5
`define BATCHQ_ALMOST_FULL 24

// Permuter queue and pipeline
`define PERMQ_DEPTH_LOG2 5
`define PERMQ_SLOWDOWN 16
`define PERMUTER_LATENCY 2

`endif

//--- common/botTypesPkg.sv
`default_nettype none

package botTypesPkg;

    // Truth table of 7 variables, index bits 6,5,4 are A,B,C
    typedef logic [127:0] botT;

    // Wanted orderings of A,B,C
    // bit 5 ABC, bit 4 ACB, bit 3 BAC, bit 2 BCA, bit 1 CAB, bit 0 CBA
    typedef logic [5:0] permuteMaskT;

    typedef enum logic {
        IDLE,
        BURST
    } permuterStateT;

endpackage

`default_nettype wire

//--- common/batchCtrlPkg.sv
`default_nettype none

`include "botPermuter_settings.svh"

package batchCtrlPkg;

    // Up to 63 bots per batch
    typedef logic [5:0] batchSizeT;

    typedef logic [`NUM_LANES-1:0] laneSelT;

    typedef logic [`LANE_DEPTH_LOG2-1:0] laneAddrT;

    typedef enum logic [1:0] {
        IDLE,
        DRAIN,
        CLOSE
    } schedStateT;

endpackage

`default_nettype wire

//--- common/laneReadBus.sv
`timescale 1ns/1ns
`default_nettype none

`include "botPermuter_settings.svh"

interface laneReadBus;
    import botTypesPkg::*;
    import batchCtrlPkg::*;

    // Read strobes, one hot, from the scheduler
    laneSelT read;

    // Per lane, each element driven by its own buffer
    botT bot [`NUM_LANES];
    permuteMaskT mask [`NUM_LANES];
    batchSizeT batchSize [`NUM_LANES];
    logic slowDown [`NUM_LANES];

    modport lane (
        input  read,
        output bot, mask, batchSize, slowDown
    );

    modport scheduler (
        output read,
        input  bot, mask, batchSize, slowDown
    );

endinterface

`default_nettype wire

//--- design/syncFifo.sv
`timescale 1ns/1ns
`default_nettype none

module syncFifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH_LOG2 = 5
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                writeEnable,
    input  logic [WIDTH-1:0]    dataIn,
    input  logic                readEnable,
    output logic [WIDTH-1:0]    dataOut,
    output logic                empty,
    output logic [DEPTH_LOG2:0] usedw
);

    logic [WIDTH-1:0] mem [2**DEPTH_LOG2];
    logic [DEPTH_LOG2-1:0] writePtr;
    logic [DEPTH_LOG2-1:0] readPtr;
    logic [DEPTH_LOG2:0] fill;

    // Head entry falls through
    assign dataOut = mem[readPtr];
    assign empty = fill == '0;
    assign usedw = fill;

    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writePtr] <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            fill <= '0;
        end else begin
            if (writeEnable) begin
                writePtr <= writePtr + 1'b1;
            end
            if (readEnable) begin
                readPtr <= readPtr + 1'b1;
            end
            case ({writeEnable, readEnable})
                2'b10: fill <= fill + 1'b1;
                2'b01: fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/batchLaneBuffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "botPermuter_settings.svh"

module batchLaneBuffer #(
    parameter int LANE = 0
) (
    input  logic                     clk,
    input  logic                     rst,
    input  botTypesPkg::botT         botIn,
    input  botTypesPkg::permuteMaskT permutesIn,
    input  logic                     endBatch,
    laneReadBus.lane                 bus
);
    import botTypesPkg::*;
    import batchCtrlPkg::*;

    localparam int DEPTH = 2 ** `LANE_DEPTH_LOG2;
    localparam int LAT = `LANE_READ_LATENCY;

    logic write;
    laneAddrT writePtr;
    laneAddrT readPtr;
    laneAddrT used;
    batchSizeT batchCount;
    batchSizeT batchSize;
    logic slowFlag;
    botT botMem [DEPTH];
    permuteMaskT maskMem [DEPTH];
    botT botPipe [LAT];
    permuteMaskT maskPipe [LAT];

    assign write = |permutesIn;
    // Running size includes a write in this cycle
    assign batchSize = batchCount + batchSizeT'(write);
    assign used = writePtr - readPtr;

    always_ff @(posedge clk) begin
        if (write) begin
            botMem[writePtr] <= botIn;
            maskMem[writePtr] <= permutesIn;
        end
    end

    // Read data reaches the bus LAT cycles after the strobe
    always_ff @(posedge clk) begin
        botPipe[0] <= botMem[readPtr];
        maskPipe[0] <= maskMem[readPtr];
        for (int i = 1; i < LAT; i++) begin
            botPipe[i] <= botPipe[i-1];
            maskPipe[i] <= maskPipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            writePtr <= '0;
            readPtr <= '0;
            batchCount <= '0;
            slowFlag <= 1'b0;
        end else begin
            writePtr <= writePtr + laneAddrT'(write);
            readPtr <= readPtr + laneAddrT'(bus.read[LANE]);
            batchCount <= endBatch ? '0 : batchSize;
            slowFlag <= (DEPTH - int'(used)) < `LANE_SLOWDOWN_FREE;
        end
    end

    assign bus.bot[LANE] = botPipe[LAT-1];
    assign bus.mask[LANE] = maskPipe[LAT-1];
    assign bus.batchSize[LANE] = batchSize;
    assign bus.slowDown[LANE] = slowFlag;

endmodule

`default_nettype wire

//--- batchScheduler/batchScheduler.sv
`timescale 1ns/1ns
`default_nettype none

`include "botPermuter_settings.svh"

module batchScheduler (
    input  logic                     clk,
    input  logic                     rst,
    input  batchCtrlPkg::laneSelT    batchesDone,
    laneReadBus.scheduler            bus,
    input  logic                     permQueueSlowDown,
    output batchCtrlPkg::laneSelT    slowDownInputs,
    output logic                     arriveWrite,
    output botTypesPkg::botT         arriveBot,
    output botTypesPkg::permuteMaskT arriveMask,
    output logic                     arriveDone
);
    import batchCtrlPkg::*;

    localparam int ENTRY_WIDTH = $bits(batchSizeT) + `NUM_LANES;
    localparam int LAT = `LANE_READ_LATENCY;

    batchSizeT doneSize;
    logic [ENTRY_WIDTH-1:0] headEntry;
    batchSizeT headSize;
    laneSelT headLane;
    logic queueEmpty;
    logic queuePop;
    logic [`BATCHQ_DEPTH_LOG2:0] queueUsed;
    logic queueAlmostFull;
    laneSelT laneSlow;
    schedStateT state;
    batchSizeT remaining;
    laneSelT activeLane;
    logic strobe;
    logic closeMark;
    laneSelT readPipe [LAT];
    logic [LAT-1:0] closePipe;
    laneSelT arriveSel;

    // Size of the batch closing this cycle, at most one lane
    always_comb begin
        doneSize = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (batchesDone[i]) begin
                doneSize = bus.batchSize[i];
            end
        end
    end

    syncFifo #(
        .WIDTH(ENTRY_WIDTH),
        .DEPTH_LOG2(`BATCHQ_DEPTH_LOG2)
    ) i_batchQueue (
        .clk(clk),
        .rst(rst),
        .writeEnable(|batchesDone),
        .dataIn({doneSize, batchesDone}),
        .readEnable(queuePop),
        .dataOut(headEntry),
        .empty(queueEmpty),
        .usedw(queueUsed)
    );

    assign {headSize, headLane} = headEntry;

    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            laneSlow[i] = bus.slowDown[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            queueAlmostFull <= 1'b0;
        end else begin
            queueAlmostFull <= queueUsed >= `BATCHQ_ALMOST_FULL;
        end
    end

    assign slowDownInputs = queueAlmostFull ? '1 : laneSlow;

    assign queuePop = state == IDLE && !queueEmpty;
    assign strobe = state == DRAIN && remaining != '0 && !permQueueSlowDown;
    assign closeMark = state == CLOSE;
    assign bus.read = strobe ? activeLane : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            remaining <= '0;
            activeLane <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (!queueEmpty) begin
                        remaining <= headSize;
                        activeLane <= headLane;
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (strobe) begin
                        remaining <= remaining - 1'b1;
                    end
                    // Empty batches go straight to the end mark
                    if (remaining == '0 || (strobe && remaining == batchSizeT'(1))) begin
                        state <= CLOSE;
                    end
                end
                CLOSE: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Strobes and end mark follow the lane data latency
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < LAT; i++) begin
                readPipe[i] <= '0;
            end
            closePipe <= '0;
        end else begin
            readPipe[0] <= bus.read;
            closePipe[0] <= closeMark;
            for (int i = 1; i < LAT; i++) begin
                readPipe[i] <= readPipe[i-1];
                closePipe[i] <= closePipe[i-1];
            end
        end
    end

    assign arriveSel = readPipe[LAT-1];
    assign arriveWrite = |arriveSel || closePipe[LAT-1];
    assign arriveDone = closePipe[LAT-1];

    // End mark has no lane selected, so its mask comes out zero
    always_comb begin
        arriveBot = '0;
        arriveMask = '0;
        for (int i = 0; i < `NUM_LANES; i++) begin
            if (arriveSel[i]) begin
                arriveBot = bus.bot[i];
                arriveMask = bus.mask[i];
            end
        end
    end

endmodule

`default_nettype wire

//--- permuter/botPermuter.sv
`timescale 1ns/1ns
`default_nettype none

module botPermuter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  botTypesPkg::botT         botIn,
    input  botTypesPkg::permuteMaskT maskIn,
    output logic                     ready,
    output botTypesPkg::botT         permutedBot,
    output logic                     permutedBotValid
);
    import botTypesPkg::*;

    permuterStateT state;
    botT heldBot;
    permuteMaskT remMask;
    permuteMaskT issueBit;
    logic [2:0] selIdx;
    logic lastIssue;
    botT reordered;

    // Output bit i takes input bit with A,B,C index bits read from posX,posY,posZ of i
    function automatic botT reorder(botT b, int posX, int posY, int posZ);
        botT r;
        logic [6:0] idx;
        for (int i = 0; i < $bits(botT); i++) begin
            idx = 7'(i);
            r[i] = b[{idx[posX], idx[posY], idx[posZ], idx[3:0]}];
        end
        return r;
    endfunction

    // Highest remaining ordering first
    always_comb begin
        selIdx = '0;
        for (int k = 0; k < $bits(permuteMaskT); k++) begin
            if (remMask[k]) begin
                selIdx = 3'(k);
            end
        end
    end

    assign issueBit = permuteMaskT'(1) << selIdx;
    assign lastIssue = (remMask & (remMask - 1'b1)) == '0;
    assign ready = state == IDLE || (state == BURST && lastIssue);

    always_comb begin
        case (selIdx)
            3'd5: reordered = heldBot;
            3'd4: reordered = reorder(heldBot, 6, 4, 5);
            3'd3: reordered = reorder(heldBot, 5, 6, 4);
            3'd2: reordered = reorder(heldBot, 5, 4, 6);
            3'd1: reordered = reorder(heldBot, 4, 6, 5);
            default: reordered = reorder(heldBot, 4, 5, 6);
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            remMask <= '0;
            permutedBotValid <= 1'b0;
        end else begin
            permutedBotValid <= state == BURST;
            if (start) begin
                remMask <= maskIn;
                // Zero mask gives no output at all
                state <= (maskIn != '0) ? BURST : IDLE;
            end else if (state == BURST) begin
                remMask <= remMask & ~issueBit;
                if (lastIssue) begin
                    state <= IDLE;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            heldBot <= botIn;
        end
        permutedBot <= reordered;
    end

endmodule

`default_nettype wire

//--- permuter/permuterStage.sv
`timescale 1ns/1ns
`default_nettype none

`include "botPermuter_settings.svh"

module permuterStage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     arriveWrite,
    input  botTypesPkg::botT         arriveBot,
    input  botTypesPkg::permuteMaskT arriveMask,
    input  logic                     arriveDone,
    output logic                     permQueueSlowDown,
    input  logic                     requestSlowDown,
    output botTypesPkg::botT         permutedBot,
    output logic                     permutedBotValid,
    output logic                     batchFinished
);
    import botTypesPkg::*;

    localparam int ENTRY_WIDTH = $bits(botT) + $bits(permuteMaskT) + 1;
    localparam int LAT = `PERMUTER_LATENCY;

    logic [ENTRY_WIDTH-1:0] headEntry;
    botT headBot;
    permuteMaskT headMask;
    logic headDone;
    logic queueEmpty;
    logic [`PERMQ_DEPTH_LOG2:0] queueUsed;
    logic permuterReady;
    logic take;
    logic [LAT-1:0] donePipe;

    syncFifo #(
        .WIDTH(ENTRY_WIDTH),
        .DEPTH_LOG2(`PERMQ_DEPTH_LOG2)
    ) i_permQueue (
        .clk(clk),
        .rst(rst),
        .writeEnable(arriveWrite),
        .dataIn({arriveBot, arriveMask, arriveDone}),
        .readEnable(take),
        .dataOut(headEntry),
        .empty(queueEmpty),
        .usedw(queueUsed)
    );

    assign {headBot, headMask, headDone} = headEntry;

    // Downstream slow-down holds back new entries only
    assign take = permuterReady && !queueEmpty && !requestSlowDown;

    always_ff @(posedge clk) begin
        if (rst) begin
            permQueueSlowDown <= 1'b0;
            donePipe <= '0;
        end else begin
            permQueueSlowDown <= queueUsed > `PERMQ_SLOWDOWN;
            donePipe[0] <= take && headDone;
            for (int i = 1; i < LAT; i++) begin
                donePipe[i] <= donePipe[i-1];
            end
        end
    end

    assign batchFinished = donePipe[LAT-1];

    botPermuter i_botPermuter (
        .clk(clk),
        .rst(rst),
        .start(take),
        .botIn(headBot),
        .maskIn(headMask),
        .ready(permuterReady),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid)
    );

endmodule

`default_nettype wire

//--- design/botPermuterTop.sv
`timescale 1ns/1ns
`default_nettype none

`include "botPermuter_settings.svh"

module botPermuterTop (
    input  logic                                                clk,
    input  logic                                                rst,
    input  logic [`NUM_LANES*$bits(botTypesPkg::botT)-1:0]      bots,
    input  logic [`NUM_LANES*$bits(botTypesPkg::permuteMaskT)-1:0] validBotsPermutes,
    input  batchCtrlPkg::laneSelT                               batchesDone,
    output batchCtrlPkg::laneSelT                               slowDownInputs,
    output botTypesPkg::botT                                    permutedBot,
    output logic                                                permutedBotValid,
    output logic                                                batchFinished,
    input  logic                                                requestSlowDown
);
    import botTypesPkg::*;

    localparam int BOT_W = $bits(botT);
    localparam int MASK_W = $bits(permuteMaskT);

    logic permQueueSlowDown;
    logic arriveWrite;
    logic arriveDone;
    botT arriveBot;
    permuteMaskT arriveMask;

    laneReadBus laneBus ();

    for (genvar g = 0; g < `NUM_LANES; g++) begin : lanes
        batchLaneBuffer #(
            .LANE(g)
        ) i_laneBuffer (
            .clk(clk),
            .rst(rst),
            .botIn(bots[g*BOT_W +: BOT_W]),
            .permutesIn(validBotsPermutes[g*MASK_W +: MASK_W]),
            .endBatch(batchesDone[g]),
            .bus(laneBus.lane)
        );
    end

    batchScheduler i_batchScheduler (
        .clk(clk),
        .rst(rst),
        .batchesDone(batchesDone),
        .bus(laneBus.scheduler),
        .permQueueSlowDown(permQueueSlowDown),
        .slowDownInputs(slowDownInputs),
        .arriveWrite(arriveWrite),
        .arriveBot(arriveBot),
        .arriveMask(arriveMask),
        .arriveDone(arriveDone)
    );

    permuterStage i_permuterStage (
        .clk(clk),
        .rst(rst),
        .arriveWrite(arriveWrite),
        .arriveBot(arriveBot),
        .arriveMask(arriveMask),
        .arriveDone(arriveDone),
        .permQueueSlowDown(permQueueSlowDown),
        .requestSlowDown(requestSlowDown),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished(batchFinished)
    );

endmodule

`default_nettype wire

//--- testbench/botPermuter_assert.sv
`timescale 1ns/1ns
`default_nettype none

`include "botPermuter_settings.svh"

module botPermuterAssert (
    input  logic                     clk,
    input  logic                     rst,
    input  batchCtrlPkg::laneSelT    batchesDone,
    input  batchCtrlPkg::laneSelT    laneRead,
    input  batchCtrlPkg::schedStateT schedState,
    input  logic                     arriveWrite,
    input  botTypesPkg::permuteMaskT arriveMask,
    input  logic                     permutedBotValid,
    input  logic                     batchFinished
);
    import batchCtrlPkg::*;

    int failCount = 0;

    doneOneHot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(batchesDone))
        else begin
            failCount++;
            $error("more than one lane closed a batch in the same cycle");
        end

    noReadWhenIdle: assert property (@(posedge clk) disable iff (rst)
        |laneRead |-> schedState != IDLE)
        else begin
            failCount++;
            $error("lane read strobe while the scheduler is idle");
        end

    // Each read brings a stored bot to the permuter stage a fixed time later
    readArrives: assert property (@(posedge clk) disable iff (rst)
        |laneRead |-> ##`LANE_READ_LATENCY (arriveWrite && arriveMask != '0))
        else begin
            failCount++;
            $error("lane read did not bring a stored bot to the permuter stage in time");
        end

    finishAlone: assert property (@(posedge clk) disable iff (rst)
        batchFinished |-> !permutedBotValid)
        else begin
            failCount++;
            $error("batchFinished came together with a permuted bot");
        end

endmodule

bind botPermuterTop botPermuterAssert i_assert (
    .clk(clk),
    .rst(rst),
    .batchesDone(batchesDone),
    .laneRead(laneBus.read),
    .schedState(i_batchScheduler.state),
    .arriveWrite(arriveWrite),
    .arriveMask(arriveMask),
    .permutedBotValid(permutedBotValid),
    .batchFinished(batchFinished)
);

`default_nettype wire

//--- testbench/botPermuterTb.sv
`timescale 1ns/1ns
`default_nettype none

`include "botPermuter_settings.svh"

module botPermuterTb;

    typedef struct packed {
        logic [7:0]   lane;
        logic [5:0]   mask;
        logic         done;
        logic [7:0]   gap;
        logic [127:0] bot;
    } rowT;

    typedef struct packed {
        logic [7:0]   lane;
        logic [5:0]   mask;
        logic [127:0] bot;
    } writeT;

    logic clk = 1'b0;
    logic rst;
    logic [`NUM_LANES*128-1:0] bots;
    logic [`NUM_LANES*6-1:0] validBotsPermutes;
    logic [`NUM_LANES-1:0] batchesDone;
    logic [`NUM_LANES-1:0] slowDownInputs;
    logic [127:0] permutedBot;
    logic permutedBotValid;
    logic batchFinished;
    logic requestSlowDown;

    int seed = 32'hb152;
    int errors = 0;
    int holdCycles = 0;
    bit tableReady = 1'b0;
    rowT rows[$];
    writeT pending[$];
    // Bit 128 marks a batch end
    logic [128:0] expected[$];

    botPermuterTop i_botPermuterTop (
        .clk(clk),
        .rst(rst),
        .bots(bots),
        .validBotsPermutes(validBotsPermutes),
        .batchesDone(batchesDone),
        .slowDownInputs(slowDownInputs),
        .permutedBot(permutedBot),
        .permutedBotValid(permutedBotValid),
        .batchFinished(batchFinished),
        .requestSlowDown(requestSlowDown)
    );

    always #10 clk = ~clk;

    task automatic compare(input logic [128:0] actual, input logic [128:0] want,
                           input string what);
        if (actual !== want) begin
            errors++;
            $display("Error at %0t ns: %s, got %h, expected %h", $time, what, actual, want);
        end
    endtask

    // Ordering XYZ puts the index bits at the positions of X,Y,Z into bits 6,5,4
    function automatic logic [127:0] permuteByOrdering(input logic [127:0] b, input int k);
        string order;
        int pos [3];
        logic [6:0] idx;
        logic [127:0] r;
        case (k)
            5: order = "ABC";
            4: order = "ACB";
            3: order = "BAC";
            2: order = "BCA";
            1: order = "CAB";
            default: order = "CBA";
        endcase
        for (int v = 0; v < 3; v++) begin
            pos[v] = 6 - (int'(order[v]) - int'("A"));
        end
        for (int i = 0; i < 128; i++) begin
            idx = 7'(i);
            r[i] = b[{idx[pos[0]], idx[pos[1]], idx[pos[2]], idx[3:0]}];
        end
        return r;
    endfunction

    task automatic addRow(input int lane, input logic [5:0] mask, input bit done,
                          input int gap);
        rowT row;
        row.lane = 8'(lane);
        row.mask = mask;
        row.done = done;
        row.gap = 8'(gap);
        for (int w = 0; w < 4; w++) begin
            row.bot[w*32 +: 32] = $random(seed);
        end
        rows.push_back(row);
    endtask

    task automatic buildTable();
        logic [5:0] mask;
        // One ordering per batch
        for (int k = 0; k < 6; k++) begin
            addRow(k % `NUM_LANES, 6'(1) << k, 1'b1, 1);
        end
        // Idle row without a write, then a mixed batch
        addRow(1, 6'h00, 1'b0, 0);
        addRow(1, 6'h3f, 1'b0, 0);
        addRow(1, 6'h15, 1'b1, 2);
        // Interleaved lanes, closed out of lane order
        for (int i = 0; i < 12; i++) begin
            mask = 6'($random(seed));
            if (mask == '0) begin
                mask = 6'h24;
            end
            addRow(i % `NUM_LANES, mask, 1'b0, 0);
        end
        addRow(2, 6'h09, 1'b1, 0);
        addRow(0, 6'h00, 1'b1, 2);
        addRow(3, 6'h30, 1'b1, 0);
        addRow(1, 6'h00, 1'b1, 0);
        // Empty batch
        addRow(3, 6'h00, 1'b1, 3);
        // Fill one lane until it asks to slow down
        for (int i = 0; i < 151; i++) begin
            addRow(0, 6'h3f, i == 59 || i == 119 || i == 150, 0);
        end
    endtask

    task automatic recordRow(input rowT row);
        writeT keep[$];
        if (row.mask != '0) begin
            pending.push_back({row.lane, row.mask, row.bot});
        end
        if (row.done) begin
            foreach (pending[p]) begin
                if (pending[p].lane == row.lane) begin
                    for (int k = 5; k >= 0; k--) begin
                        if (pending[p].mask[k]) begin
                            expected.push_back({1'b0, permuteByOrdering(pending[p].bot, k)});
                        end
                    end
                end else begin
                    keep.push_back(pending[p]);
                end
            end
            pending = keep;
            expected.push_back({1'b1, 128'b0});
        end
    endtask

    task automatic clearInputs();
        bots <= '0;
        validBotsPermutes <= '0;
        batchesDone <= '0;
    endtask

    task automatic applyRow(input rowT row);
        @(posedge clk);
        while (slowDownInputs[row.lane]) begin
            holdCycles++;
            clearInputs();
            @(posedge clk);
        end
        clearInputs();
        bots[row.lane*128 +: 128] <= row.bot;
        validBotsPermutes[row.lane*6 +: 6] <= row.mask;
        batchesDone[row.lane] <= row.done;
        recordRow(row);
        repeat (row.gap) begin
            @(posedge clk);
            clearInputs();
        end
    endtask

    task automatic checkOutputs();
        logic [128:0] head;
        if (permutedBotValid) begin
            if (expected.size() == 0) begin
                errors++;
                $display("A permuted bot arrived at %0t ns with nothing left to expect", $time);
            end else begin
                head = expected.pop_front();
                compare({1'b0, permutedBot}, head, "permuted bot");
            end
        end
        if (batchFinished) begin
            if (expected.size() == 0) begin
                errors++;
                $display("batchFinished pulsed at %0t ns with no batch left", $time);
            end else begin
                head = expected.pop_front();
                compare({1'b1, 128'b0}, head, "batchFinished before the batch was complete");
            end
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            checkOutputs();
        end
    end

    // Random downstream back-pressure
    always @(posedge clk) begin
        if (rst) begin
            requestSlowDown <= 1'b0;
        end else begin
            requestSlowDown <= ($random(seed) & 3) == 0;
        end
    end

    initial begin
        wait (tableReady);
        repeat (rows.size() * 8 + 500) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", rows.size() * 8 + 500);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        rst = 1'b1;
        bots = '0;
        validBotsPermutes = '0;
        batchesDone = '0;
        requestSlowDown = 1'b0;
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        compare(permutedBotValid, 0, "permutedBotValid after reset");
        compare(batchFinished, 0, "batchFinished after reset");
        compare(slowDownInputs, 0, "slowDownInputs after reset");
        foreach (rows[r]) begin
            applyRow(rows[r]);
        end
        @(posedge clk);
        clearInputs();
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        // Let any stray output show up
        repeat (20) @(negedge clk);
        compare(holdCycles != 0, 1, "lane slow-down never held a row");
        errors += i_botPermuterTop.i_assert.failCount;
        $display("errors %0d, expected left %0d", errors, expected.size());
        if (errors == 0 && expected.size() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- botPermuter.f
+incdir+common
common/botTypesPkg.sv
common/batchCtrlPkg.sv
common/laneReadBus.sv
design/syncFifo.sv
design/batchLaneBuffer.sv
batchScheduler/batchScheduler.sv
permuter/botPermuter.sv
permuter/permuterStage.sv
design/botPermuterTop.sv
testbench/botPermuter_assert.sv
testbench/botPermuterTb.sv
